// ==== ram_decoder.f ====
src/axi_pkg.sv
src/mem_map_pkg.sv
src/axi_mem_if.sv
src/region_router.sv
src/axi_ram_slave.sv
src/ram_decoder.sv
verif/tb_ram_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds tb_ram_decoder with Verilator, runs it and scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_ram_decoder
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
   -f ram_decoder.f --top-module "$TOP" -o "$TOP"

./obj_dir/"$TOP" | tee "$LOG"

if grep -q "test failed" "$LOG"; then
   echo "simulation reported failure, see $LOG"
   exit 1
fi

echo "simulation finished, log in $LOG"

// ==== verif/tb_ram_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ram_decoder;
   import axi_pkg::*;

   localparam int DATA_W      = 64;
   localparam int ID_W        = 4;
   localparam int WORDS       = 256;
   localparam int STRB_W      = DATA_W / 8;
   localparam int OFFSET_W    = $clog2(STRB_W);   // byte offset inside a word
   localparam int IDX_W       = $clog2(WORDS);
   localparam int CLK_PERIOD  = 8;
   localparam int DRIVE_DELAY = 1;
   localparam int TIMEOUT     = 200;              // cycles per wait loop
   localparam logic [31:0] SEED = 32'hab39_910a;

   logic              clk;
   logic              rst_n;
   logic              axi_awvalid;
   axi_addr_t         axi_awaddr;
   logic [ID_W-1:0]   axi_awid;
   logic              axi_wvalid;
   logic [DATA_W-1:0] axi_wdata;
   logic [STRB_W-1:0] axi_wstrb;
   logic              axi_bready;
   logic              axi_arvalid;
   axi_addr_t         axi_araddr;
   logic [ID_W-1:0]   axi_arid;
   logic              axi_rready;
   logic              axi_awready;
   logic              axi_wready;
   logic              axi_bvalid;
   logic [ID_W-1:0]   axi_bid;
   axi_resp_t         axi_bresp;
   logic              axi_arready;
   logic              axi_rvalid;
   logic [DATA_W-1:0] axi_rdata;
   logic [ID_W-1:0]   axi_rid;
   axi_resp_t         axi_rresp;
   logic              axi_rlast;

   // reference copies of the two RAMs
   logic [DATA_W-1:0] kernel_model [WORDS];
   logic [DATA_W-1:0] arg_model    [WORDS];

   int mismatches;
   int timeouts;
   int protocol_errs;

   ram_decoder #(.data_width(DATA_W), .id_width(ID_W), .ram_words(WORDS)) dut (.*);

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // bit 31 means kernel, else bit 16 means argument, else kernel
   function automatic bit is_arg(input axi_addr_t a);
      return (a[31] == 1'b0) && (a[16] == 1'b1);
   endfunction

   function automatic int word_of(input axi_addr_t a);
      return int'((a >> OFFSET_W) % WORDS);
   endfunction

   function automatic logic [DATA_W-1:0] model_read(input axi_addr_t a);
      return is_arg(a) ? arg_model[word_of(a)] : kernel_model[word_of(a)];
   endfunction

   task automatic model_write(input axi_addr_t a, input logic [DATA_W-1:0] d,
                              input logic [STRB_W-1:0] s);
      logic [DATA_W-1:0] word;
      word = model_read(a);
      for (int i = 0; i < STRB_W; i++) begin
         if (s[i])
            word[i*8 +: 8] = d[i*8 +: 8];
      end
      if (is_arg(a))
         arg_model[word_of(a)] = word;
      else
         kernel_model[word_of(a)] = word;
   endtask

   ////////////////////////////////////////
   // random helpers
   ////////////////////////////////////////

   // kind 0 kernel, 1 argument, 2 unmapped
   function automatic axi_addr_t make_addr(input int kind, input int index);
      axi_addr_t a;
      a = $urandom();
      a[OFFSET_W-1:0] = '0;
      a[OFFSET_W +: IDX_W] = index[IDX_W-1:0];
      a[31] = (kind == 0);
      a[16] = (kind == 1);
      if (kind == 0)
         a[16] = a[20];   // don't care under bit 31
      return a;
   endfunction

   function automatic logic [DATA_W-1:0] rand_data();
      return {$urandom(), $urandom()};
   endfunction

   function automatic logic [ID_W-1:0] rand_id();
      logic [31:0] r;
      r = $urandom();
      return r[ID_W-1:0];
   endfunction

   function automatic logic [STRB_W-1:0] rand_strb();
      logic [31:0] r;
      r = $urandom();
      return r[STRB_W-1:0];
   endfunction

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_rdata(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch rdata: got %h, expected %h", got, exp);
         mismatches++;
      end
   endtask

   task automatic check_id(input string name, input logic [ID_W-1:0] got,
                           input logic [ID_W-1:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got %h, expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_rlast(input logic got);
      if (got !== 1'b1) begin
         $display("mismatch rlast: got %h, expected %h", got, 1'b1);
         mismatches++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s", what);
      timeouts++;
   endtask

   // B held stable, no second write taken
   task automatic check_write_hold(input logic [ID_W-1:0] id);
      if (!axi_bvalid) begin
         $display("bvalid dropped before the write response was taken");
         protocol_errs++;
      end
      if (axi_awready || axi_wready) begin
         $display("write request accepted while a write response was pending");
         protocol_errs++;
      end
      check_id("bid", axi_bid, id);
      check_resp("bresp", axi_bresp, RESP_OKAY);
   endtask

   task automatic check_read_hold(input logic [ID_W-1:0] id, input logic [DATA_W-1:0] exp);
      if (!axi_rvalid) begin
         $display("rvalid dropped before the read data was taken");
         protocol_errs++;
      end
      if (axi_arready) begin
         $display("read request accepted while read data was pending");
         protocol_errs++;
      end
      check_rdata(axi_rdata, exp);
      check_id("rid", axi_rid, id);
      check_resp("rresp", axi_rresp, RESP_OKAY);
      check_rlast(axi_rlast);
   endtask

   ////////////////////////////////////////
   // bus tasks
   ////////////////////////////////////////

   // entered and left 1 ns after a rising edge; outputs sampled on the falling edge
   task automatic do_write(input axi_addr_t addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input logic [ID_W-1:0] id,
                           input int stall);
      int cnt;
      axi_awaddr  = addr;
      axi_awid    = id;
      axi_wdata   = data;
      axi_wstrb   = strb;
      axi_awvalid = 1'b1;
      axi_wvalid  = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (!(axi_awready && axi_wready) && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= TIMEOUT) begin
         report_timeout("write request was never accepted");
         axi_awvalid = 1'b0;
         axi_wvalid  = 1'b0;
         return;
      end
      @(posedge clk);
      #DRIVE_DELAY;
      axi_awvalid = 1'b0;
      axi_wvalid  = 1'b0;
      model_write(addr, data, strb);
      cnt = 0;
      @(negedge clk);
      while (!axi_bvalid && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= TIMEOUT) begin
         report_timeout("write response never arrived");
         return;
      end
      for (int k = 0; k < stall; k++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         axi_awaddr  = ~addr;   // may decode to the other region
         axi_wdata   = ~data;   // second write offered, must wait
         axi_awvalid = 1'b1;
         axi_wvalid  = 1'b1;
         @(negedge clk);
         check_write_hold(id);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      axi_awvalid = 1'b0;
      axi_wvalid  = 1'b0;
      axi_bready  = 1'b1;
      @(negedge clk);
      check_write_hold(id);
      @(posedge clk);
      #DRIVE_DELAY;
      axi_bready = 1'b0;
   endtask

   task automatic do_read(input axi_addr_t addr, input logic [ID_W-1:0] id, input int stall);
      int                cnt;
      logic [DATA_W-1:0] expected;
      axi_araddr  = addr;
      axi_arid    = id;
      axi_arvalid = 1'b1;
      cnt = 0;
      @(negedge clk);
      while (!axi_arready && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= TIMEOUT) begin
         report_timeout("read request was never accepted");
         axi_arvalid = 1'b0;
         return;
      end
      @(posedge clk);
      #DRIVE_DELAY;
      axi_arvalid = 1'b0;
      expected = model_read(addr);   // word as of acceptance
      cnt = 0;
      @(negedge clk);
      while (!axi_rvalid && cnt < TIMEOUT) begin
         @(negedge clk);
         cnt++;
      end
      if (cnt >= TIMEOUT) begin
         report_timeout("read data never arrived");
         return;
      end
      for (int k = 0; k < stall; k++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         axi_araddr  = ~addr;
         axi_arvalid = 1'b1;
         @(negedge clk);
         check_read_hold(id, expected);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      axi_arvalid = 1'b0;
      axi_rready  = 1'b1;
      @(negedge clk);
      check_read_hold(id, expected);
      @(posedge clk);
      #DRIVE_DELAY;
      axi_rready = 1'b0;
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin
      axi_addr_t addr_q[$];
      axi_addr_t a;
      axi_addr_t b;
      int        idx;
      int        kind;
      void'($urandom(SEED));
      mismatches    = 0;
      timeouts      = 0;
      protocol_errs = 0;
      rst_n       = 1'b0;
      axi_awvalid = 1'b0;
      axi_awaddr  = '0;
      axi_awid    = '0;
      axi_wvalid  = 1'b0;
      axi_wdata   = '0;
      axi_wstrb   = '0;
      axi_bready  = 1'b0;
      axi_arvalid = 1'b0;
      axi_araddr  = '0;
      axi_arid    = '0;
      axi_rready  = 1'b0;
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      @(negedge clk);
      if (axi_bvalid || axi_rvalid) begin
         $display("response valid high after reset");
         protocol_errs++;
      end
      @(posedge clk);
      #DRIVE_DELAY;

      // known contents in both RAMs
      for (int w = 0; w < WORDS; w++) begin
         do_write(make_addr(0, w), rand_data(), '1, rand_id(), 0);
         do_write(make_addr(1, w), rand_data(), '1, rand_id(), 0);
      end

      // full-strobe writes, then read back with back-pressure
      for (int n = 0; n < 40; n++) begin
         a = make_addr($urandom_range(0, 1), $urandom_range(0, WORDS - 1));
         addr_q.push_back(a);
         do_write(a, rand_data(), '1, rand_id(), $urandom_range(0, 5));
      end
      foreach (addr_q[i])
         do_read(addr_q[i], rand_id(), $urandom_range(0, 5));

      // same offset in each region, unmapped hits kernel
      for (int n = 0; n < 8; n++) begin
         idx = $urandom_range(0, WORDS - 1);
         a = make_addr(0, idx);
         b = make_addr(1, idx);
         do_write(a, rand_data(), '1, rand_id(), 0);
         do_write(b, rand_data(), '1, rand_id(), 0);
         do_read(a, rand_id(), 0);
         do_read(b, rand_id(), 0);
         do_write(make_addr(2, idx), rand_data(), '1, rand_id(), 0);
         do_read(a, rand_id(), 0);
         do_read(b, rand_id(), 0);
      end

      // partial strobes
      for (int n = 0; n < 40; n++) begin
         a = make_addr($urandom_range(0, 2), $urandom_range(0, WORDS - 1));
         do_write(a, rand_data(), rand_strb(), rand_id(), $urandom_range(0, 4));
         do_read(a, rand_id(), $urandom_range(0, 4));
      end

      // write one region while reading the other
      for (int n = 0; n < 16; n++) begin
         kind = $urandom_range(0, 1);
         a = make_addr(kind, $urandom_range(0, WORDS - 1));
         b = make_addr(1 - kind, $urandom_range(0, WORDS - 1));
         fork
            do_write(a, rand_data(), rand_strb(), rand_id(), $urandom_range(0, 3));
            do_read(b, rand_id(), $urandom_range(0, 3));
         join
         do_read(a, rand_id(), 0);
      end

      $display("errors: %0d mismatches, %0d timeouts, %0d protocol",
               mismatches, timeouts, protocol_errs);
      if (mismatches + timeouts + protocol_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src/ram_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_decoder #(
   parameter int data_width = axi_pkg::AXI_DATA_WIDTH_DEF,
   parameter int id_width   = axi_pkg::AXI_ID_WIDTH_DEF,
   parameter int ram_words  = mem_map_pkg::RAM_WORDS_DEF
) (
   input  logic                      clk,
   input  logic                      rst_n,

   // host side
   input  logic                      axi_awvalid,
   input  axi_pkg::axi_addr_t        axi_awaddr,
   input  logic [id_width-1:0]       axi_awid,
   input  logic                      axi_wvalid,
   input  logic [data_width-1:0]     axi_wdata,
   input  logic [data_width/8-1:0]   axi_wstrb,
   input  logic                      axi_bready,
   input  logic                      axi_arvalid,
   input  axi_pkg::axi_addr_t        axi_araddr,
   input  logic [id_width-1:0]       axi_arid,
   input  logic                      axi_rready,

   output logic                      axi_awready,
   output logic                      axi_wready,
   output logic                      axi_bvalid,
   output logic [id_width-1:0]       axi_bid,
   output axi_pkg::axi_resp_t        axi_bresp,
   output logic                      axi_arready,
   output logic                      axi_rvalid,
   output logic [data_width-1:0]     axi_rdata,
   output logic [id_width-1:0]       axi_rid,
   output axi_pkg::axi_resp_t        axi_rresp,
   output logic                      axi_rlast
);

   axi_mem_if #(.data_width(data_width), .id_width(id_width)) host ();
   axi_mem_if #(.data_width(data_width), .id_width(id_width)) kernel_bus ();
   axi_mem_if #(.data_width(data_width), .id_width(id_width)) arg_bus ();

   ////////////////////////////////////////
   // plain ports onto the host bundle
   ////////////////////////////////////////

   assign host.awvalid = axi_awvalid;
   assign host.awaddr  = axi_awaddr;
   assign host.awid    = axi_awid;
   assign host.wvalid  = axi_wvalid;
   assign host.wdata   = axi_wdata;
   assign host.wstrb   = axi_wstrb;
   assign host.bready  = axi_bready;
   assign host.arvalid = axi_arvalid;
   assign host.araddr  = axi_araddr;
   assign host.arid    = axi_arid;
   assign host.rready  = axi_rready;

   assign axi_awready  = host.awready;
   assign axi_wready   = host.wready;
   assign axi_bvalid   = host.bvalid;
   assign axi_bid      = host.bid;
   assign axi_bresp    = host.bresp;
   assign axi_arready  = host.arready;
   assign axi_rvalid   = host.rvalid;
   assign axi_rdata    = host.rdata;
   assign axi_rid      = host.rid;
   assign axi_rresp    = host.rresp;
   assign axi_rlast    = host.rlast;

   region_router #(.data_width(data_width), .id_width(id_width)) router (
      .clk        (clk),
      .rst_n      (rst_n),
      .host       (host.subordinate),
      .kernel_bus (kernel_bus.manager),
      .arg_bus    (arg_bus.manager)
   );

   // bit 31 set, or unmapped
   axi_ram_slave #(
      .data_width (data_width),
      .id_width   (id_width),
      .ram_words  (ram_words)
   ) kernel_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (kernel_bus.subordinate)
   );

   // bit 31 clear, bit 16 set
   axi_ram_slave #(
      .data_width (data_width),
      .id_width   (id_width),
      .ram_words  (ram_words)
   ) arg_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (arg_bus.subordinate)
   );

endmodule

`default_nettype wire

// ==== src/axi_ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_ram_slave #(
   parameter int data_width = axi_pkg::AXI_DATA_WIDTH_DEF,
   parameter int id_width   = axi_pkg::AXI_ID_WIDTH_DEF,
   parameter int ram_words  = mem_map_pkg::RAM_WORDS_DEF
) (
   input logic            clk,
   input logic            rst_n,
   axi_mem_if.subordinate bus
);
   import axi_pkg::*;

   localparam int strb_width  = data_width / 8;
   localparam int byte_bits   = $clog2(strb_width);   // byte offset inside a word
   localparam int index_width = $clog2(ram_words);

   logic [data_width-1:0]  mem [ram_words];

   logic [index_width-1:0] wr_index;
   logic [index_width-1:0] rd_index;
   logic                   wr_accept;
   logic                   rd_accept;

   logic                   b_pending;
   logic [id_width-1:0]    bid_q;
   logic                   r_pending;
   logic [id_width-1:0]    rid_q;
   logic [data_width-1:0]  rdata_q;

   // upper address bits drop out here, so unmapped space aliases the array
   assign wr_index = bus.awaddr[byte_bits +: index_width];
   assign rd_index = bus.araddr[byte_bits +: index_width];

   ////////////////////////////////////////
   // write path
   ////////////////////////////////////////

   // aw and w are taken together, one B outstanding
   assign wr_accept   = bus.awvalid && bus.wvalid && !b_pending;
   assign bus.awready = wr_accept;
   assign bus.wready  = wr_accept;

   always_ff @(posedge clk) begin
      if (wr_accept) begin
         for (int i = 0; i < strb_width; i++) begin
            if (bus.wstrb[i])
               mem[wr_index][i*8 +: 8] <= bus.wdata[i*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         b_pending <= 1'b0;
      end else if (wr_accept) begin
         b_pending <= 1'b1;
      end else if (bus.bvalid && bus.bready) begin
         b_pending <= 1'b0;   // drops the cycle after bready
      end
   end

   always_ff @(posedge clk) begin
      if (wr_accept)
         bid_q <= bus.awid;
   end

   assign bus.bvalid = b_pending;
   assign bus.bid    = bid_q;
   assign bus.bresp  = RESP_OKAY;

   ////////////////////////////////////////
   // read path
   ////////////////////////////////////////

   assign bus.arready = !r_pending;   // blocked while R is held
   assign rd_accept   = bus.arvalid && !r_pending;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r_pending <= 1'b0;
      end else if (rd_accept) begin
         r_pending <= 1'b1;
      end else if (bus.rvalid && bus.rready) begin
         r_pending <= 1'b0;
      end
   end

   // word is captured at acceptance and held under back-pressure
   // a write accepted one cycle earlier is already in mem
   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rdata_q <= mem[rd_index];
         rid_q   <= bus.arid;
      end
   end

   assign bus.rvalid = r_pending;
   assign bus.rdata  = rdata_q;
   assign bus.rid    = rid_q;
   assign bus.rresp  = RESP_OKAY;
   assign bus.rlast  = 1'b1;   // single beat, always the last

endmodule

`default_nettype wire

// ==== src/region_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module region_router #(
   parameter int data_width = axi_pkg::AXI_DATA_WIDTH_DEF,
   parameter int id_width   = axi_pkg::AXI_ID_WIDTH_DEF
) (
   input logic            clk,
   input logic            rst_n,
   axi_mem_if.subordinate host,
   axi_mem_if.manager     kernel_bus,
   axi_mem_if.manager     arg_bus
);
   import axi_pkg::*;
   import mem_map_pkg::*;

   mem_region_e           aw_region;   // live decode of awaddr
   mem_region_e           ar_region;   // live decode of araddr
   mem_region_e           wr_sel;
   mem_region_e           rd_sel;
   logic                  wr_busy;     // b response owed to host
   logic                  rd_busy;     // r response owed to host
   logic                  aw_hs;
   logic                  ar_hs;
   logic                  b_hs;
   logic                  r_hs;
   logic                  bvalid_mux;
   logic [id_width-1:0]   bid_mux;
   axi_resp_t             bresp_mux;
   logic                  rvalid_mux;
   logic [data_width-1:0] rdata_mux;
   logic [id_width-1:0]   rid_mux;
   axi_resp_t             rresp_mux;
   logic                  rlast_mux;

   // bit 31 first, then bit 16, anything else aliases the kernel RAM
   function automatic mem_region_e decode_region(input axi_addr_t addr);
      if (addr[KERNEL_SEL_BIT])
         return REGION_KERNEL;
      if (addr[ARG_SEL_BIT])
         return REGION_ARG;
      return REGION_KERNEL;
   endfunction

   assign aw_region = decode_region(host.awaddr);
   assign ar_region = decode_region(host.araddr);

   ////////////////////////////////////////
   // request side
   ////////////////////////////////////////

   // payload fans out, only the valids are steered
   assign kernel_bus.awaddr = host.awaddr;
   assign kernel_bus.awid   = host.awid;
   assign kernel_bus.wdata  = host.wdata;
   assign kernel_bus.wstrb  = host.wstrb;
   assign kernel_bus.araddr = host.araddr;
   assign kernel_bus.arid   = host.arid;
   assign arg_bus.awaddr    = host.awaddr;
   assign arg_bus.awid      = host.awid;
   assign arg_bus.wdata     = host.wdata;
   assign arg_bus.wstrb     = host.wstrb;
   assign arg_bus.araddr    = host.araddr;
   assign arg_bus.arid      = host.arid;

   // w follows the aw decode, both go in the same cycle
   assign kernel_bus.awvalid = host.awvalid && !wr_busy && (aw_region == REGION_KERNEL);
   assign kernel_bus.wvalid  = host.wvalid  && !wr_busy && (aw_region == REGION_KERNEL);
   assign arg_bus.awvalid    = host.awvalid && !wr_busy && (aw_region == REGION_ARG);
   assign arg_bus.wvalid     = host.wvalid  && !wr_busy && (aw_region == REGION_ARG);
   assign kernel_bus.arvalid = host.arvalid && !rd_busy && (ar_region == REGION_KERNEL);
   assign arg_bus.arvalid    = host.arvalid && !rd_busy && (ar_region == REGION_ARG);

   assign host.awready = !wr_busy &&
                         ((aw_region == REGION_ARG) ? arg_bus.awready : kernel_bus.awready);
   assign host.wready  = !wr_busy &&
                         ((aw_region == REGION_ARG) ? arg_bus.wready : kernel_bus.wready);
   assign host.arready = !rd_busy &&
                         ((ar_region == REGION_ARG) ? arg_bus.arready : kernel_bus.arready);

   assign aw_hs = host.awvalid && host.awready;
   assign ar_hs = host.arvalid && host.arready;
   assign b_hs  = host.bvalid && host.bready;
   assign r_hs  = host.rvalid && host.rready;

   ////////////////////////////////////////
   // per-direction select
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_busy <= 1'b0;
         wr_sel  <= REGION_KERNEL;
      end else if (aw_hs) begin
         wr_busy <= 1'b1;
         wr_sel  <= aw_region;   // held until the b handshake
      end else if (b_hs) begin
         wr_busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_busy <= 1'b0;
         rd_sel  <= REGION_KERNEL;
      end else if (ar_hs) begin
         rd_busy <= 1'b1;
         rd_sel  <= ar_region;
      end else if (r_hs) begin
         rd_busy <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // response side
   ////////////////////////////////////////

   assign kernel_bus.bready = host.bready && wr_busy && (wr_sel == REGION_KERNEL);
   assign arg_bus.bready    = host.bready && wr_busy && (wr_sel == REGION_ARG);
   assign kernel_bus.rready = host.rready && rd_busy && (rd_sel == REGION_KERNEL);
   assign arg_bus.rready    = host.rready && rd_busy && (rd_sel == REGION_ARG);

   always_comb begin
      if (wr_sel == REGION_ARG) begin
         bvalid_mux = arg_bus.bvalid;
         bid_mux    = arg_bus.bid;
         bresp_mux  = arg_bus.bresp;
      end else begin
         bvalid_mux = kernel_bus.bvalid;
         bid_mux    = kernel_bus.bid;
         bresp_mux  = kernel_bus.bresp;
      end
   end

   always_comb begin
      if (rd_sel == REGION_ARG) begin
         rvalid_mux = arg_bus.rvalid;
         rdata_mux  = arg_bus.rdata;
         rid_mux    = arg_bus.rid;
         rresp_mux  = arg_bus.rresp;
         rlast_mux  = arg_bus.rlast;
      end else begin
         rvalid_mux = kernel_bus.rvalid;
         rdata_mux  = kernel_bus.rdata;
         rid_mux    = kernel_bus.rid;
         rresp_mux  = kernel_bus.rresp;
         rlast_mux  = kernel_bus.rlast;
      end
   end

   assign host.bvalid = wr_busy && bvalid_mux;
   assign host.bid    = bid_mux;
   assign host.bresp  = bresp_mux;
   assign host.rvalid = rd_busy && rvalid_mux;
   assign host.rdata  = rdata_mux;
   assign host.rid    = rid_mux;
   assign host.rresp  = rresp_mux;
   assign host.rlast  = rlast_mux;

endmodule

`default_nettype wire

// ==== src/axi_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-beat AXI channel bundle, no burst fields
interface axi_mem_if #(
   parameter int data_width = axi_pkg::AXI_DATA_WIDTH_DEF,
   parameter int id_width   = axi_pkg::AXI_ID_WIDTH_DEF
);
   import axi_pkg::*;

   localparam int strb_width = data_width / 8;

   // write address
   logic                  awvalid;
   logic                  awready;
   axi_addr_t             awaddr;
   logic [id_width-1:0]   awid;

   // write data
   logic                  wvalid;
   logic                  wready;
   logic [data_width-1:0] wdata;
   logic [strb_width-1:0] wstrb;

   // write response
   logic                  bvalid;
   logic                  bready;
   logic [id_width-1:0]   bid;
   axi_resp_t             bresp;

   // read address
   logic                  arvalid;
   logic                  arready;
   axi_addr_t             araddr;
   logic [id_width-1:0]   arid;

   // read data
   logic                  rvalid;
   logic                  rready;
   logic [data_width-1:0] rdata;
   logic [id_width-1:0]   rid;
   axi_resp_t             rresp;
   logic                  rlast;

   modport manager (
      output awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
      output arvalid, araddr, arid, rready,
      input  awready, wready, bvalid, bid, bresp,
      input  arready, rvalid, rdata, rid, rresp, rlast
   );

   modport subordinate (
      input  awvalid, awaddr, awid, wvalid, wdata, wstrb, bready,
      input  arvalid, araddr, arid, rready,
      output awready, wready, bvalid, bid, bresp,
      output arready, rvalid, rdata, rid, rresp, rlast
   );

endinterface

`default_nettype wire

// ==== src/mem_map_pkg.sv ====
`default_nettype none

// address map of the kernel and argument RAMs
package mem_map_pkg;

   ////////////////////////////////////////
   // region select bits
   ////////////////////////////////////////

   // kernel region wins whenever this bit is set
   localparam int KERNEL_SEL_BIT = 31;

   // argument region needs bit 31 clear and this bit set
   localparam int ARG_SEL_BIT = 16;

   ////////////////////////////////////////
   // regions
   ////////////////////////////////////////

   // unmapped addresses land in REGION_KERNEL
   typedef enum logic {
      REGION_KERNEL = 1'b0,
      REGION_ARG    = 1'b1
   } mem_region_e;

   ////////////////////////////////////////
   // ram geometry
   ////////////////////////////////////////

   // depth in words, power of two; the word index is log2 of this
   localparam int RAM_WORDS_DEF = 1024;

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
`default_nettype none

// AXI fields shared by the host port, the router and both RAMs
package axi_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int AXI_ADDR_WIDTH     = 32;  // bit 31 takes part in the decode
   localparam int AXI_DATA_WIDTH_DEF = 64;  // top level overrides this
   localparam int AXI_ID_WIDTH_DEF   = 4;

   ////////////////////////////////////////
   // channel field types
   ////////////////////////////////////////

   typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;

   // bresp / rresp encoding
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;  // only code either RAM returns

endpackage

`default_nettype wire
